//--- files.f
hw/bpu_pkg.sv
hw/decode_pkg.sv
hw/bpu_update_if.sv
hw/bpu_predict.sv
hw/bpu_issue_stage.sv
hw/bpf.sv
hw/bpu_top.sv
verification/bpu_assertions.sv
verification/bpu_tb.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - hw/bpu_pkg.sv
  - hw/decode_pkg.sv
  - hw/bpu_update_if.sv
  - hw/bpu_predict.sv
  - hw/bpu_issue_stage.sv
  - hw/bpf.sv
  - hw/bpu_top.sv
  - target: simulation
    files:
      - verification/bpu_assertions.sv
      - verification/bpu_tb.sv

//--- verification/bpu_tb.sv
// branch predictor testbench
`timescale 1ns/1ns

module bpu_tb;
	import decode_pkg::*;

	localparam int CLK_NS      = 4;
	localparam int CMP_TRIALS  = 6;
	// reset plus two cycles per branch plus flush and peek cycles
	localparam int TEST_CYCLES = 10 + 2 * (2 + 8 * CMP_TRIALS + 2 + 4 + 1) + 6;
	localparam int TIMEOUT_NS  = (TEST_CYCLES + 50) * CLK_NS;

	logic         clk;
	logic         rst_n_i;
	logic         fetch_valid_i;
	logic [31:0]  fetch_pc_i;
	branch_type_t br_type_i;
	cmp_type_t    cmp_type_i;
	logic         branch_link_i;
	logic [25:0]  offs_i;
	logic [31:0]  rj_i;
	logic [31:0]  rd_i;
	logic         stall_i;
	logic         csr_flush_i;
	logic [31:0]  csr_target_i;
	logic         pred_taken_o;
	logic [31:0]  pred_npc_o;
	logic         redirect_o;
	logic [31:0]  redirect_pc_o;
	logic [31:0]  link_pc_o;
	logic         ex_taken_o;

	int err_count;
	int test_err_base;
	int test_count;
	// responses sampled by run_branch
	logic        got_taken;
	logic [31:0] got_npc;
	logic        got_redirect;
	logic [31:0] got_redirect_pc;
	logic [31:0] got_link_pc;
	logic        got_ex_taken;

	bpu_top DUT (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			err_count++;
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (err_count == test_err_base) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s FAILED, %0d errors", name, err_count - test_err_base);
		end
		test_err_base = err_count;
	endtask

	// conditional and jirl layout is imm16 then rj then rd
	function automatic logic [25:0] pack_offs16(input logic [15:0] imm, input logic [4:0] rj,
			input logic [4:0] rd);
		return {imm, rj, rd};
	endfunction

	// b and bl layout puts the low 16 bits on top
	function automatic logic [25:0] pack_offs26(input logic [25:0] imm);
		return {imm[15:0], imm[25:16]};
	endfunction

	function automatic logic [31:0] offs16_bytes(input logic [15:0] imm);
		return {{14{imm[15]}}, imm, 2'b00};
	endfunction

	function automatic logic [31:0] offs26_bytes(input logic [25:0] imm);
		return {{4{imm[25]}}, imm, 2'b00};
	endfunction

	// reference outcome of a compare opcode
	function automatic logic model_condition(input cmp_type_t ct, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		logic signed [31:0] sb;
		sa = a;
		sb = b;
		case (ct)
			CMP_EQL: return a == b;
			CMP_NEQ: return a != b;
			CMP_LSS: return sa < sb;
			CMP_GER: return sa > sb;
			CMP_LEQ: return !(sa > sb);
			CMP_GEQ: return !(sa < sb);
			CMP_LTU: return a < b;
			default: return !(a < b);
		endcase
	endfunction

	// fetch in one cycle and resolve in the next
	task automatic run_branch(input logic [31:0] pc, input branch_type_t bt,
			input cmp_type_t ct, input logic link, input logic [25:0] offs,
			input logic [31:0] rj, input logic [31:0] rd, input logic stall);
		@(negedge clk);
		fetch_valid_i = 1'b1;
		fetch_pc_i    = pc;
		br_type_i     = bt;
		cmp_type_i    = ct;
		branch_link_i = link;
		offs_i        = offs;
		#1;
		got_taken = pred_taken_o;
		got_npc   = pred_npc_o;
		// operands arrive in the issue cycle
		@(negedge clk);
		fetch_valid_i = 1'b0;
		rj_i          = rj;
		rd_i          = rd;
		stall_i       = stall;
		#1;
		got_redirect    = redirect_o;
		got_redirect_pc = redirect_pc_o;
		got_link_pc     = link_pc_o;
		got_ex_taken    = ex_taken_o;
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------

	task automatic test_cold();
		logic [31:0] pc;
		pc = 32'h0000_1000;
		// taken beq with a backward target
		run_branch(pc, BRANCH_CONDITION, CMP_EQL, 1'b0, pack_offs16(16'hfff0, 5'd4, 5'd5),
			32'd7, 32'd7, 1'b0);
		expect_equal("pred_taken_o", got_taken, 32'd0);
		expect_equal("pred_npc_o", got_npc, pc + 32'd4);
		expect_equal("redirect_o", got_redirect, 32'd1);
		expect_equal("redirect_pc_o", got_redirect_pc, pc + offs16_bytes(16'hfff0));
		expect_equal("ex_taken_o", got_ex_taken, 32'd1);
		pc = 32'h0000_1104;
		run_branch(pc, BRANCH_CONDITION, CMP_EQL, 1'b0, pack_offs16(16'h0010, 5'd4, 5'd5),
			32'd5, 32'd6, 1'b0);
		expect_equal("pred_taken_o", got_taken, 32'd0);
		expect_equal("pred_npc_o", got_npc, pc + 32'd4);
		expect_equal("redirect_o", got_redirect, 32'd0);
		expect_equal("ex_taken_o", got_ex_taken, 32'd0);
		report_test("cold_predictor");
	endtask

	task automatic test_compare();
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic        exp_taken;
		cmp_type_t   ct;
		// fresh tag for every trial keeps the predictor cold
		pc = 32'h0002_0000;
		for (int op = 0; op < 8; op++) begin
			ct = cmp_type_t'(op);
			for (int n = 0; n < CMP_TRIALS; n++) begin
				a = $urandom;
				case ($urandom_range(2, 0))
					0: b = a;
					1: b = a ^ 32'h8000_0000;
					default: b = $urandom;
				endcase
				exp_taken = model_condition(ct, a, b);
				run_branch(pc, BRANCH_CONDITION, ct, 1'b0, pack_offs16(16'h0010, 5'd4, 5'd5),
					a, b, 1'b0);
				expect_equal($sformatf("ex_taken_o %s", ct.name()), got_ex_taken, exp_taken);
				expect_equal($sformatf("redirect_o %s", ct.name()), got_redirect, exp_taken);
				pc = pc + 32'h40;
			end
		end
		report_test("compare_opcodes");
	endtask

	task automatic test_training();
		logic [31:0] pc;
		pc = 32'h0000_3048;
		run_branch(pc, BRANCH_CONDITION, CMP_NEQ, 1'b0, pack_offs16(16'h0020, 5'd4, 5'd5),
			32'd1, 32'd2, 1'b0);
		expect_equal("redirect_o", got_redirect, 32'd1);
		// counter now weakly taken and target stored
		run_branch(pc, BRANCH_CONDITION, CMP_NEQ, 1'b0, pack_offs16(16'h0020, 5'd4, 5'd5),
			32'd1, 32'd2, 1'b0);
		expect_equal("pred_taken_o", got_taken, 32'd1);
		expect_equal("pred_npc_o", got_npc, pc + offs16_bytes(16'h0020));
		expect_equal("redirect_o", got_redirect, 32'd0);
		expect_equal("ex_taken_o", got_ex_taken, 32'd1);
		report_test("training");
	endtask

	task automatic test_call_return();
		logic [31:0] call_pc;
		logic [31:0] call2_pc;
		logic [31:0] ret_pc;
		logic [25:0] ret_offs;
		call_pc  = 32'h0000_5000;
		call2_pc = 32'h0000_7020;
		ret_pc   = 32'h0000_6010;
		// jirl r0, r1, 0
		ret_offs = pack_offs16(16'h0000, 5'd1, 5'd0);
		run_branch(call_pc, BRANCH_IMMEDIATE, CMP_EQL, 1'b1, pack_offs26(26'h0000100),
			32'd0, 32'd0, 1'b0);
		expect_equal("redirect_o", got_redirect, 32'd1);
		expect_equal("redirect_pc_o", got_redirect_pc, call_pc + offs26_bytes(26'h0000100));
		expect_equal("link_pc_o", got_link_pc, call_pc + 32'd4);
		// first return is unknown to the buffer
		run_branch(ret_pc, BRANCH_INDIRECT, CMP_EQL, 1'b0, ret_offs, call_pc + 32'd4,
			32'd0, 1'b0);
		expect_equal("pred_taken_o", got_taken, 32'd0);
		expect_equal("redirect_pc_o", got_redirect_pc, call_pc + 32'd4);
		// second call with a backward target
		run_branch(call2_pc, BRANCH_IMMEDIATE, CMP_EQL, 1'b1, pack_offs26(26'h3ffff00),
			32'd0, 32'd0, 1'b0);
		expect_equal("redirect_pc_o", got_redirect_pc, call2_pc + offs26_bytes(26'h3ffff00));
		expect_equal("link_pc_o", got_link_pc, call2_pc + 32'd4);
		run_branch(ret_pc, BRANCH_INDIRECT, CMP_EQL, 1'b0, ret_offs, call2_pc + 32'd4,
			32'd0, 1'b0);
		expect_equal("pred_taken_o", got_taken, 32'd1);
		expect_equal("pred_npc_o", got_npc, call2_pc + 32'd4);
		expect_equal("redirect_o", got_redirect, 32'd0);
		expect_equal("ex_taken_o", got_ex_taken, 32'd1);
		report_test("call_return");
	endtask

	task automatic test_csr_stall();
		logic [31:0] pc;
		pc = 32'h0000_9014;
		@(negedge clk);
		csr_flush_i  = 1'b1;
		csr_target_i = 32'h8000_0100;
		#1;
		expect_equal("redirect_o", redirect_o, 32'd1);
		expect_equal("redirect_pc_o", redirect_pc_o, 32'h8000_0100);
		@(negedge clk);
		csr_flush_i = 1'b0;
		// cold prediction and taken outcome resolved under stall
		run_branch(pc, BRANCH_CONDITION, CMP_EQL, 1'b0, pack_offs16(16'h0008, 5'd4, 5'd5),
			32'd3, 32'd3, 1'b1);
		expect_equal("redirect_o", got_redirect, 32'd0);
		// drop the held branch while stall stays high
		@(negedge clk);
		csr_flush_i  = 1'b1;
		csr_target_i = 32'h8000_0200;
		#1;
		expect_equal("redirect_o", redirect_o, 32'd1);
		expect_equal("redirect_pc_o", redirect_pc_o, 32'h8000_0200);
		@(negedge clk);
		csr_flush_i = 1'b0;
		stall_i     = 1'b0;
		fetch_pc_i  = pc;
		#1;
		expect_equal("pred_taken_o", pred_taken_o, 32'd0);
		expect_equal("pred_npc_o", pred_npc_o, pc + 32'd4);
		report_test("csr_flush_stall");
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin : main
		void'($urandom(90));
		err_count     = 0;
		test_err_base = 0;
		test_count    = 0;
		rst_n_i       = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pc_i    = '0;
		br_type_i     = BRANCH_INVALID;
		cmp_type_i    = CMP_EQL;
		branch_link_i = 1'b0;
		offs_i        = '0;
		rj_i          = '0;
		rd_i          = '0;
		stall_i       = 1'b0;
		csr_flush_i   = 1'b0;
		csr_target_i  = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		test_cold();
		test_compare();
		test_training();
		test_call_return();
		test_csr_stall();
		$display("summary: %0d tests run, %0d errors, %0d assertion failures", test_count,
			err_count, DUT.u_assertions.fail_count);
		if (err_count == 0 && DUT.u_assertions.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule : bpu_tb

//--- verification/bpu_assertions.sv
// branch predictor top checks
`timescale 1ns/1ns

module bpu_assertions (
	input logic        clk,
	input logic        rst_n_i,
	input logic        stall_i,
	input logic        csr_flush_i,
	input logic [31:0] fetch_pc_i,
	input logic        pred_taken_o,
	input logic [31:0] pred_npc_o,
	input logic        redirect_o
);

	// number of failed checks
	int unsigned fail_count = 0;

	// ------------------------------------------------------------
	// resolve side
	// ------------------------------------------------------------

	// nothing resolves while reset is held
	assert property (@(posedge clk) !rst_n_i |-> !redirect_o)
		else begin
			fail_count++;
			$error("redirect raised during reset");
		end

	// a stalled branch may only redirect through a csr flush
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(redirect_o && stall_i) |-> csr_flush_i)
		else begin
			fail_count++;
			$error("redirect under stall without csr flush");
		end

	// ------------------------------------------------------------
	// fetch side
	// ------------------------------------------------------------

	// not taken means sequential fetch
	assert property (@(posedge clk) disable iff (!rst_n_i)
		!pred_taken_o |-> (pred_npc_o == fetch_pc_i + 32'd4))
		else begin
			fail_count++;
			$error("sequential next pc wrong");
		end

endmodule : bpu_assertions

bind bpu_top bpu_assertions u_assertions (.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
	.csr_flush_i(csr_flush_i), .fetch_pc_i(fetch_pc_i), .pred_taken_o(pred_taken_o),
	.pred_npc_o(pred_npc_o), .redirect_o(redirect_o));

//--- hw/bpu_top.sv
// branch prediction subsystem top
`timescale 1ns/1ns

module bpu_top (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           fetch_valid_i,
	input  logic [31:0]                    fetch_pc_i,
	input  decode_pkg::branch_type_t       br_type_i,
	input  decode_pkg::cmp_type_t          cmp_type_i,
	input  logic                           branch_link_i,
	input  logic [decode_pkg::OFFS_WIDTH-1:0] offs_i,
	input  logic [31:0]                    rj_i,
	input  logic [31:0]                    rd_i,
	input  logic                           stall_i,
	input  logic                           csr_flush_i,
	input  logic [31:0]                    csr_target_i,
	output logic                           pred_taken_o,
	output logic [31:0]                    pred_npc_o,
	output logic                           redirect_o,
	output logic [31:0]                    redirect_pc_o,
	output logic [31:0]                    link_pc_o,
	output logic                           ex_taken_o
);
	import bpu_pkg::*;
	import decode_pkg::*;

	bpu_predict_t fetch_predict;
	branch_info_t fetch_info;
	logic         iss_valid;
	logic [31:0]  iss_pc;
	branch_info_t iss_info;
	bpu_predict_t iss_predict;

	bpu_update_if upd_if ();

	// decoder fields for the fetched pc
	assign fetch_info.branch_type = br_type_i;
	assign fetch_info.cmp_type    = cmp_type_i;
	assign fetch_info.branch_link = branch_link_i;
	assign fetch_info.offs        = offs_i;

	bpu_predict u_predict (.clk(clk), .rst_n_i(rst_n_i), .fetch_pc_i(fetch_pc_i),
		.upd_if(upd_if.pred), .predict_o(fetch_predict));

	bpu_issue_stage u_issue (.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
		.valid_i(fetch_valid_i), .pc_i(fetch_pc_i), .info_i(fetch_info),
		.predict_i(fetch_predict), .upd_if(upd_if.pipe), .valid_o(iss_valid),
		.pc_o(iss_pc), .info_o(iss_info), .predict_o(iss_predict));

	bpf u_bpf (.csr_flush_i(csr_flush_i), .stall_i(stall_i), .valid_i(iss_valid),
		.pc_i(iss_pc), .rj_i(rj_i), .rd_i(rd_i), .csr_target_i(csr_target_i),
		.info_i(iss_info), .predict_i(iss_predict), .upd_if(upd_if.src));

	// fetch side outputs
	assign pred_taken_o  = fetch_predict.taken;
	assign pred_npc_o    = {fetch_predict.npc, 2'b00};
	// resolve side outputs
	assign redirect_o    = upd_if.flush;
	assign redirect_pc_o = upd_if.br_target;
	assign link_pc_o     = upd_if.link_pc;
	assign ex_taken_o    = upd_if.br_taken;

endmodule : bpu_top

//--- hw/bpf.sv
// branch resolution and predictor feedback
`timescale 1ns/1ns

module bpf (
	input  logic                     csr_flush_i,
	input  logic                     stall_i,
	input  logic                     valid_i,
	input  logic [31:0]              pc_i,
	input  logic [31:0]              rj_i,
	input  logic [31:0]              rd_i,
	input  logic [31:0]              csr_target_i,
	input  decode_pkg::branch_info_t info_i,
	input  bpu_pkg::bpu_predict_t    predict_i,
	bpu_update_if.src                upd_if
);
	import bpu_pkg::*;
	import decode_pkg::*;

	// register indices live in the low offset bits
	logic [4:0]  rj_index;
	logic [4:0]  rd_index;
	logic [31:0] offs_26;
	logic [31:0] offs_16;
	logic        cond_taken;
	logic        taken;
	logic [31:0] target;
	logic [31:0] predict_npc;
	logic        target_miss;
	logic        direction_miss;
	logic        predict_miss;
	logic        is_branch;
	br_kind_t    kind;

	// ------------------------------------------------------------
	// offsets and target
	// ------------------------------------------------------------

	assign rj_index = info_i.offs[9:5];
	assign rd_index = info_i.offs[4:0];
	// offs26 is split, high part in [9:0]
	assign offs_26  = {{4{info_i.offs[9]}}, info_i.offs[9:0], info_i.offs[25:10], 2'b00};
	assign offs_16  = {{14{info_i.offs[25]}}, info_i.offs[25:10], 2'b00};

	always_comb begin : proc_target
		case (info_i.branch_type)
			BRANCH_IMMEDIATE: target = pc_i + offs_26;
			BRANCH_INDIRECT:  target = rj_i + offs_16;
			BRANCH_CONDITION: target = cond_taken ? pc_i + offs_16 : pc_i + 32'd4;
			default:          target = pc_i + 32'd4;
		endcase
	end

	// ------------------------------------------------------------
	// direction
	// ------------------------------------------------------------

	always_comb begin : proc_cmp
		case (info_i.cmp_type)
			CMP_EQL: cond_taken = rj_i == rd_i;
			CMP_NEQ: cond_taken = rj_i != rd_i;
			CMP_LSS: cond_taken = $signed(rj_i) < $signed(rd_i);
			CMP_GER: cond_taken = $signed(rj_i) > $signed(rd_i);
			CMP_LEQ: cond_taken = $signed(rj_i) <= $signed(rd_i);
			CMP_GEQ: cond_taken = $signed(rj_i) >= $signed(rd_i);
			CMP_LTU: cond_taken = rj_i < rd_i;
			CMP_GEU: cond_taken = rj_i >= rd_i;
			default: cond_taken = 1'b0;
		endcase
	end

	assign is_branch = valid_i && (info_i.branch_type != BRANCH_INVALID);
	// jumps always taken, conditionals by compare
	assign taken = is_branch &&
		((info_i.branch_type == BRANCH_CONDITION) ? cond_taken : 1'b1);

	// ------------------------------------------------------------
	// classification
	// ------------------------------------------------------------

	always_comb begin : proc_kind
		if ((info_i.branch_type == BRANCH_INDIRECT && rd_index == 5'd1) || info_i.branch_link) begin
			kind = CALL;
		end else if (info_i.branch_type == BRANCH_INDIRECT && rj_index == 5'd1 &&
				offs_16 == 32'd0) begin
			kind = RETURN;
		end else if (info_i.branch_type == BRANCH_IMMEDIATE ||
				info_i.branch_type == BRANCH_INDIRECT) begin
			kind = ABSOLUTE;
		end else begin
			kind = PC_RELATIVE;
		end
	end

	// ------------------------------------------------------------
	// mispredict and feedback
	// ------------------------------------------------------------

	assign predict_npc    = {predict_i.npc, 2'b00};
	assign target_miss    = predict_npc != target;
	assign direction_miss = predict_i.taken != taken;
	// a wrong target only matters when we jumped
	assign predict_miss   = (target_miss & predict_i.taken) | direction_miss;

	assign upd_if.flush       = (valid_i & ~stall_i & predict_miss) | csr_flush_i;
	assign upd_if.br_taken    = taken;
	assign upd_if.pc          = pc_i[31:2];
	assign upd_if.br_target   = csr_flush_i ? csr_target_i : target;
	assign upd_if.br_kind     = kind;
	assign upd_if.btb_update  = is_branch & ~stall_i;
	assign upd_if.lpht_update = is_branch & ~stall_i;
	assign upd_if.lphr        = predict_i.lphr;
	assign upd_if.lphr_index  = pc_i[LPHT_ADDR_WIDTH+1:2];
	// committed stack pointer after this branch
	assign upd_if.ras_ptr     = (kind == CALL)   ? predict_i.ras_ptr + 1'b1 :
	                            (kind == RETURN) ? predict_i.ras_ptr - 1'b1 :
	                            predict_i.ras_ptr;
	assign upd_if.link_pc     = pc_i + 32'd4;

endmodule : bpf

//--- hw/bpu_issue_stage.sv
// issue stage pipeline register
`timescale 1ns/1ns

module bpu_issue_stage (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     stall_i,
	input  logic                     valid_i,
	input  logic [31:0]              pc_i,
	input  decode_pkg::branch_info_t info_i,
	input  bpu_pkg::bpu_predict_t    predict_i,
	bpu_update_if.pipe               upd_if,
	output logic                     valid_o,
	output logic [31:0]              pc_o,
	output decode_pkg::branch_info_t info_o,
	output bpu_pkg::bpu_predict_t    predict_o
);

	// ------------------------------------------------------------
	// valid flag
	// ------------------------------------------------------------

	// flush wins, fetch during a flush is dropped
	always_ff @(posedge clk or negedge rst_n_i) begin : proc_valid
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else if (upd_if.flush) begin
			valid_o <= 1'b0;
		end else if (!stall_i) begin
			valid_o <= valid_i;
		end
	end

	// ------------------------------------------------------------
	// payload
	// ------------------------------------------------------------

	// held while stalled
	always_ff @(posedge clk) begin : proc_payload
		if (!stall_i) begin
			pc_o      <= pc_i;
			info_o    <= info_i;
			predict_o <= predict_i;
		end
	end

endmodule : bpu_issue_stage

//--- hw/bpu_predict.sv
// fetch stage branch predictor
`timescale 1ns/1ns

module bpu_predict (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [31:0]           fetch_pc_i,
	bpu_update_if.pred            upd_if,
	output bpu_pkg::bpu_predict_t predict_o
);
	import bpu_pkg::*;

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	// target buffer
	logic [BTB_ENTRIES-1:0]     btb_valid;
	logic [BTB_TAG_WIDTH-1:0]   btb_tag [BTB_ENTRIES];
	logic [29:0]                btb_target [BTB_ENTRIES];
	br_kind_t                   btb_kind [BTB_ENTRIES];
	// pattern table
	logic [1:0]                 lpht [LPHT_ENTRIES];
	// return stack, committed state only
	logic [29:0]                ras [RAS_DEPTH];
	logic [RAS_PTR_WIDTH-1:0]   ras_ptr;

	// lookup side
	logic [BTB_IDX_WIDTH-1:0]   rd_idx;
	logic [BTB_TAG_WIDTH-1:0]   rd_tag;
	logic [LPHT_ADDR_WIDTH-1:0] rd_lpht_idx;
	logic [RAS_PTR_WIDTH-1:0]   ras_top_ptr;
	logic                       rd_hit;
	logic [1:0]                 rd_cnt;
	br_kind_t                   rd_kind;
	logic                       rd_taken;
	logic [29:0]                rd_target;
	logic [29:0]                seq_npc;

	// update side
	logic [BTB_IDX_WIDTH-1:0]   wr_idx;
	logic [BTB_TAG_WIDTH-1:0]   wr_tag;
	logic [1:0]                 wr_cnt;
	logic [RAS_PTR_WIDTH-1:0]   ras_wr_ptr;
	logic                       btb_write;
	logic                       ras_commit;

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------

	assign rd_idx      = fetch_pc_i[BTB_IDX_WIDTH+1:2];
	assign rd_tag      = fetch_pc_i[31:BTB_IDX_WIDTH+2];
	assign rd_lpht_idx = fetch_pc_i[LPHT_ADDR_WIDTH+1:2];
	// top of stack sits one below the pointer
	assign ras_top_ptr = ras_ptr - 1'b1;
	assign seq_npc     = fetch_pc_i[31:2] + 30'd1;

	assign rd_hit  = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
	assign rd_cnt  = lpht[rd_lpht_idx];
	assign rd_kind = btb_kind[rd_idx];

	always_comb begin : proc_lookup
		rd_taken  = 1'b0;
		rd_target = btb_target[rd_idx];
		if (rd_hit) begin
			// only pc-relative branches follow the counter
			rd_taken = (rd_kind == PC_RELATIVE) ? rd_cnt[1] : 1'b1;
			if (rd_kind == RETURN) begin
				rd_target = ras[ras_top_ptr];
			end
		end
	end

	assign predict_o.taken   = rd_taken;
	assign predict_o.npc     = rd_taken ? rd_target : seq_npc;
	assign predict_o.br_kind = rd_kind;
	assign predict_o.lphr    = rd_cnt;
	assign predict_o.ras_ptr = ras_ptr;

	// ------------------------------------------------------------
	// update
	// ------------------------------------------------------------

	assign wr_idx    = upd_if.pc[BTB_IDX_WIDTH-1:0];
	assign wr_tag    = upd_if.pc[29:BTB_IDX_WIDTH];
	assign btb_write = upd_if.btb_update & upd_if.br_taken;
	// call pushes at the pointer it started from
	assign ras_wr_ptr = upd_if.ras_ptr - 1'b1;
	assign ras_commit = upd_if.btb_update &
		((upd_if.br_kind == CALL) || (upd_if.br_kind == RETURN));

	// saturating counter step
	always_comb begin : proc_cnt
		if (upd_if.br_taken) begin
			wr_cnt = (upd_if.lphr == 2'b11) ? 2'b11 : upd_if.lphr + 2'b01;
		end else begin
			wr_cnt = (upd_if.lphr == 2'b00) ? 2'b00 : upd_if.lphr - 2'b01;
		end
	end

	// entry valid bits, counters and stack pointer
	always_ff @(posedge clk or negedge rst_n_i) begin : proc_ctrl
		if (!rst_n_i) begin
			btb_valid <= '0;
			ras_ptr   <= '0;
			// weakly not taken
			for (int i = 0; i < LPHT_ENTRIES; i++) begin
				lpht[i] <= 2'b01;
			end
		end else begin
			if (btb_write) begin
				btb_valid[wr_idx] <= 1'b1;
			end
			if (upd_if.lpht_update) begin
				lpht[upd_if.lphr_index] <= wr_cnt;
			end
			if (ras_commit) begin
				ras_ptr <= upd_if.ras_ptr;
			end
		end
	end

	// buffer payload and stack entries
	always_ff @(posedge clk) begin : proc_mem
		if (btb_write) begin
			btb_tag[wr_idx]    <= wr_tag;
			btb_target[wr_idx] <= upd_if.br_target[31:2];
			btb_kind[wr_idx]   <= upd_if.br_kind;
		end
		if (ras_commit && (upd_if.br_kind == CALL)) begin
			ras[ras_wr_ptr] <= upd_if.link_pc[31:2];
		end
	end

endmodule : bpu_predict

//--- hw/bpu_update_if.sv
// predictor update bus
`timescale 1ns/1ns

interface bpu_update_if;
	import bpu_pkg::*;

	logic                       flush;
	logic                       br_taken;
	// word address of the resolved branch
	logic [29:0]                pc;
	logic [31:0]                br_target;
	br_kind_t                   br_kind;
	logic                       btb_update;
	logic                       lpht_update;
	logic [1:0]                 lphr;
	logic [LPHT_ADDR_WIDTH-1:0] lphr_index;
	logic [RAS_PTR_WIDTH-1:0]   ras_ptr;
	logic [31:0]                link_pc;

	// feedback stage drives everything
	modport src (output flush, br_taken, pc, br_target, br_kind, btb_update,
		lpht_update, lphr, lphr_index, ras_ptr, link_pc);
	// predictor consumes the table updates
	modport pred (input flush, br_taken, pc, br_target, br_kind, btb_update,
		lpht_update, lphr, lphr_index, ras_ptr, link_pc);
	// issue register only needs the flush
	modport pipe (input flush);

endinterface : bpu_update_if

//--- hw/decode_pkg.sv
// branch decode definitions
package decode_pkg;

	// width of the raw offset field of the instruction
	localparam int OFFS_WIDTH = 26;

	// branch class as given by the decoder
	typedef enum logic [1:0] {
		BRANCH_INVALID,
		BRANCH_IMMEDIATE,
		BRANCH_INDIRECT,
		BRANCH_CONDITION
	} branch_type_t;

	// compare opcode of a conditional branch
	typedef enum logic [2:0] {
		CMP_EQL,
		CMP_NEQ,
		CMP_LSS,
		CMP_GER,
		CMP_LEQ,
		CMP_GEQ,
		CMP_LTU,
		CMP_GEU
	} cmp_type_t;

	// decoded branch fields
	typedef struct packed {
		branch_type_t            branch_type;
		cmp_type_t               cmp_type;
		logic                    branch_link;
		logic [OFFS_WIDTH-1:0]   offs;
	} branch_info_t;

endpackage : decode_pkg

//--- hw/bpu_pkg.sv
// branch predictor definitions
package bpu_pkg;

	// ------------------------------------------------------------
	// table geometry
	// ------------------------------------------------------------

	// direct mapped target buffer, indexed by pc[5:2]
	localparam int BTB_ENTRIES   = 16;
	localparam int BTB_IDX_WIDTH = $clog2(BTB_ENTRIES);
	// tag is the rest of the word address
	localparam int BTB_TAG_WIDTH = 30 - BTB_IDX_WIDTH;

	// local pattern table, 2-bit counters
	localparam int LPHT_ADDR_WIDTH = 6;
	localparam int LPHT_ENTRIES    = 1 << LPHT_ADDR_WIDTH;

	// return stack, pointer wraps
	localparam int RAS_DEPTH     = 8;
	localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH);

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------

	// how the target of a stored branch is found
	typedef enum logic [1:0] {
		CALL,
		RETURN,
		ABSOLUTE,
		PC_RELATIVE
	} br_kind_t;

	// prediction carried along with the fetched instruction
	typedef struct packed {
		logic                     taken;
		logic [29:0]              npc;
		br_kind_t                 br_kind;
		logic [1:0]               lphr;
		logic [RAS_PTR_WIDTH-1:0] ras_ptr;
	} bpu_predict_t;

endpackage : bpu_pkg
